//--- logic/ethBusPkg.sv
/*
 * Shared definitions for the Ethernet chip bus controller:
 * bus word types, command word fields, status bits and AXI register map
 */

package ethBusPkg;

    // ---------------------
    // Widths with a meaning
    // ---------------------
    typedef logic [7:0]  regOffset_t;   // Chip register offset 0x00..0xFF
    typedef logic [15:0] busWord_t;     // Word on the chip address/data bus
    typedef logic [3:0]  axiAddr_t;     // AXI4-Lite byte address
    typedef logic [31:0] axiData_t;     // AXI data word

    // ---------------------
    // Command word layout
    // 0(4) DMA Reset Write Word Offset(8) Data(16)
    // ---------------------
    localparam int CmdDmaBit    = 27;
    localparam int CmdResetBit  = 26;
    localparam int CmdWriteBit  = 25;
    localparam int CmdWordBit   = 24;   // 1 for 16-bit access, 0 for byte
    localparam int CmdOffsetLsb = 16;   // Offset in bits 23..16
    localparam int CmdDataLsb   = 0;    // Data in bits 15..0

    // ---------------------
    // Status word layout
    // ---------------------
    localparam int StatPresentBit = 31;
    localparam int StatErrorBit   = 30;
    localparam int StatInitReqBit = 28;
    localparam int StatIdleBit    = 19;  // Bus engine idle, lastData in 15..0

    // ---------------------
    // AXI register map
    // ---------------------
    localparam axiAddr_t RegCommand = 4'h0;
    localparam axiAddr_t RegStatus  = 4'h4;
    localparam axiAddr_t RegControl = 4'h8;  // Bit 0 clears init request

endpackage

//--- logic/ethAxiRegs.sv
/*
 * AXI4-Lite register slave for the Ethernet chip bus controller
 * Command, status and control registers, command and reset pulses
 */

`timescale 1ns/1ps

module ethAxiRegs (
    input  logic                 sysclk,
    input  logic                 reset,
    // AXI4-Lite slave
    input  ethBusPkg::axiAddr_t  awaddr,
    input  logic                 awvalid,
    output logic                 awready,
    input  ethBusPkg::axiData_t  wdata,
    input  logic                 wvalid,
    output logic                 wready,
    output logic                 bvalid,
    input  logic                 bready,
    output logic [1:0]           bresp,
    input  ethBusPkg::axiAddr_t  araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output logic                 rvalid,
    input  logic                 rready,
    output ethBusPkg::axiData_t  rdata,
    output logic [1:0]           rresp,
    // Bus cycle engine
    input  logic                 busIdle,
    input  ethBusPkg::busWord_t  lastData,
    output logic                 cmdStart,
    output logic                 cmdDma,
    output logic                 cmdWrite,
    output logic                 cmdWord,
    output ethBusPkg::regOffset_t cmdOffset,
    output ethBusPkg::busWord_t  cmdData,
    // Reset sequencer
    input  logic                 initReq,
    input  logic                 chipReady,
    output logic                 softReset,
    output logic                 initClear
);

    logic                wrFire;       // Write address and data taken this cycle
    logic                rdFire;       // Read address taken this cycle
    logic                cmdWriteEn;   // Write to command register, not a reset
    logic                busBusy;
    logic                errorFlag;    // Command dropped while busy or not ready
    ethBusPkg::axiData_t statusWord;

    assign bresp = 2'b00;   // Always OKAY
    assign rresp = 2'b00;

    assign wrFire  = awready && awvalid && wvalid;
    assign rdFire  = arready && arvalid;
    assign busBusy = !busIdle || cmdStart || !chipReady;  // cmdStart covers the launch cycle

    assign cmdWriteEn = wrFire && (awaddr == ethBusPkg::RegCommand)
                        && !wdata[ethBusPkg::CmdResetBit];

    // --------------------
    // Status word
    // --------------------
    always_comb begin
        statusWord = '0;
        statusWord[ethBusPkg::StatPresentBit] = 1'b1;   // Chip always fitted
        statusWord[ethBusPkg::StatErrorBit]   = errorFlag;
        statusWord[ethBusPkg::StatInitReqBit] = initReq;
        statusWord[ethBusPkg::StatIdleBit]    = busIdle;
        statusWord[15:0]                      = lastData;
    end

    // --------------------
    // Write channel
    // --------------------
    always_ff @(posedge sysclk or negedge reset) begin
        if (!reset) begin
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            cmdStart  <= 1'b0;
            softReset <= 1'b0;
            initClear <= 1'b0;
            errorFlag <= 1'b0;
        end else begin
            // Both ready together for one cycle unless a response is pending
            awready <= awvalid && wvalid && !awready && !bvalid;
            wready  <= awvalid && wvalid && !awready && !bvalid;

            if (wrFire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;   // Response held until taken

            softReset <= wrFire && (awaddr == ethBusPkg::RegCommand)
                         && wdata[ethBusPkg::CmdResetBit];
            initClear <= wrFire && (awaddr == ethBusPkg::RegControl) && wdata[0];
            cmdStart  <= cmdWriteEn && !busBusy;

            if (cmdWriteEn)
                errorFlag <= busBusy;   // Set on drop, cleared on accept
        end
    end

    // Command fields stay valid alongside cmdStart
    always_ff @(posedge sysclk) begin
        if (cmdWriteEn && !busBusy) begin
            cmdDma    <= wdata[ethBusPkg::CmdDmaBit];
            cmdWrite  <= wdata[ethBusPkg::CmdWriteBit];
            cmdWord   <= wdata[ethBusPkg::CmdWordBit];
            cmdOffset <= wdata[ethBusPkg::CmdOffsetLsb +: 8];
            cmdData   <= wdata[ethBusPkg::CmdDataLsb +: 16];
        end
    end

    // --------------------
    // Read channel
    // --------------------
    always_ff @(posedge sysclk or negedge reset) begin
        if (!reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;  // One-cycle pulse
            if (rdFire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge sysclk) begin
        if (rdFire)   // Data frozen while rvalid waits
            rdata <= (araddr == ethBusPkg::RegStatus) ? statusWord : '0;
    end

endmodule

//--- logic/ethChipReset.sv
/*
 * Chip reset sequencer: reset pin low time, settling wait,
 * init request flag and chip ready indication
 */

`timescale 1ns/1ps

module ethChipReset #(
    parameter int ResetAssertCycles = 491520,   // 10 ms at 49.152 MHz
    parameter int ResetWaitCycles   = 2457600   // 50 ms settling
) (
    input  logic sysclk,
    input  logic reset,
    input  logic softReset,   // Restart the sequence
    input  logic initClear,   // Software took the init request
    output logic chipRstN,
    output logic initReq,
    output logic chipReady
);

    localparam int MaxCycles = (ResetAssertCycles > ResetWaitCycles) ?
                               ResetAssertCycles : ResetWaitCycles;
    localparam int CntWidth  = $clog2(MaxCycles + 1);

    typedef enum logic [1:0] {
        RstAssert,  // Chip reset pin held low
        RstWait,    // Pin released, chip settling
        RstReady
    } rstState_t;

    rstState_t           state;
    logic [CntWidth-1:0] count;

    assign chipRstN  = (state != RstAssert);
    assign chipReady = (state == RstReady);

    always_ff @(posedge sysclk or negedge reset) begin
        if (!reset) begin
            state   <= RstAssert;
            count   <= '0;
            initReq <= 1'b0;
        end else if (softReset) begin
            state   <= RstAssert;   // Start over, drop readiness
            count   <= '0;
            initReq <= 1'b0;
        end else begin
            case (state)
                RstAssert: begin
                    if (count == CntWidth'(ResetAssertCycles - 1)) begin
                        state <= RstWait;
                        count <= '0;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                RstWait: begin
                    if (count == CntWidth'(ResetWaitCycles - 1)) begin
                        state   <= RstReady;
                        initReq <= 1'b1;   // Ask software to set up the chip
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                default: begin
                    if (initClear)
                        initReq <= 1'b0;
                end
            endcase
        end
    end

endmodule

//--- logic/ethBusCycle.sv
/*
 * Bus cycle engine for the 16-bit chip bus
 * Byte-enable address word, strobe FSM for address, write and read phases
 */

`timescale 1ns/1ps

module ethBusCycle (
    input  logic                  sysclk,
    input  logic                  reset,
    input  logic                  cmdStart,
    input  logic                  cmdDma,
    input  logic                  cmdWrite,
    input  logic                  cmdWord,
    input  ethBusPkg::regOffset_t cmdOffset,
    input  ethBusPkg::busWord_t   cmdData,
    output logic                  busIdle,
    output ethBusPkg::busWord_t   lastData,   // Also the write data source
    output logic                  chipCmd,    // 1 address, 0 data
    output logic                  chipRdN,
    output logic                  chipWrN,
    inout  wire  [15:0]           chipData
);

    typedef enum logic [3:0] {
        StIdle,
        StAddrStart,  // 2 cycles, strobe falls on the second
        StAddrHold,   // 2 cycles low
        StAddrEnd,    // 2 cycles high, then data phase
        StWrStart,    // 2 cycles, strobe falls on the second
        StWrHold,
        StWrEnd,
        StRdStart,
        StRdHold,     // 2 cycles
        StRdEnd       // Sample, then release
    } busState_t;

    busState_t             state, stateNext;
    logic                  phase, phaseNext;   // Second cycle of a 2-cycle state
    logic                  wrReg;
    logic                  wordReg;
    ethBusPkg::regOffset_t offsetReg;
    ethBusPkg::busWord_t   addrWord;
    logic [1:0]            tail;

    // --------------------
    // Address translation
    // --------------------
    // Upper nibble holds the byte enables of the 32-bit chunk
    assign tail = offsetReg[1:0];
    always_comb begin
        addrWord        = {8'h00, offsetReg};
        addrWord[12]    = (tail == 2'd0);
        addrWord[13]    = (!wordReg && tail == 2'd1) || (wordReg && tail == 2'd0);
        addrWord[14]    = (tail == 2'd2);
        addrWord[15]    = (!wordReg && tail == 2'd3) || (wordReg && tail == 2'd2);
    end

    // Drive the bus except while the chip reads out
    assign chipData = chipRdN ? (chipCmd ? addrWord : lastData) : 16'hzzzz;

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        stateNext = state;
        phaseNext = 1'b0;
        case (state)
            StIdle:
                if (cmdStart)
                    stateNext = cmdDma ? (cmdWrite ? StWrStart : StRdStart) : StAddrStart;
            StAddrStart:
                if (!phase) phaseNext = 1'b1;
                else        stateNext = StAddrHold;
            StAddrHold:
                if (!phase) phaseNext = 1'b1;
                else        stateNext = StAddrEnd;
            StAddrEnd:
                if (!phase) phaseNext = 1'b1;
                else        stateNext = wrReg ? StWrStart : StRdStart;
            StWrStart:
                if (!phase) phaseNext = 1'b1;
                else        stateNext = StWrHold;
            StWrHold:  stateNext = StWrEnd;
            StWrEnd:   stateNext = StIdle;
            StRdStart: stateNext = StRdHold;
            StRdHold:
                if (!phase) phaseNext = 1'b1;
                else        stateNext = StRdEnd;
            StRdEnd:
                if (!phase) phaseNext = 1'b1;
                else        stateNext = StIdle;
            default:   stateNext = StIdle;
        endcase
    end

    // --------------------
    // State and pin registers
    // --------------------
    // Pins are decoded from the next state so they change with it
    always_ff @(posedge sysclk or negedge reset) begin
        if (!reset) begin
            state    <= StIdle;
            phase    <= 1'b0;
            chipCmd  <= 1'b1;
            chipRdN  <= 1'b1;
            chipWrN  <= 1'b1;
            busIdle  <= 1'b1;
            lastData <= '0;
        end else begin
            state   <= stateNext;
            phase   <= phaseNext;
            chipCmd <= (stateNext == StIdle) || (stateNext == StAddrStart)
                       || (stateNext == StAddrHold) || (stateNext == StAddrEnd);
            chipWrN <= !(((stateNext == StAddrStart || stateNext == StWrStart) && phaseNext)
                         || stateNext == StAddrHold || stateNext == StWrHold);
            chipRdN <= !(stateNext == StRdStart || stateNext == StRdHold
                         || stateNext == StRdEnd);
            busIdle <= (stateNext == StIdle) || (stateNext == StWrEnd)
                       || (stateNext == StRdEnd && phaseNext);   // High on last cycle

            if (cmdStart && cmdWrite && state == StIdle)
                lastData <= cmdData;        // Write data known at start
            else if (state == StRdEnd && !phase)
                lastData <= chipData;       // Read sample point
        end
    end

    // Command latch
    always_ff @(posedge sysclk) begin
        if (cmdStart && state == StIdle) begin
            wrReg     <= cmdWrite;
            wordReg   <= cmdWord;
            offsetReg <= cmdOffset;
        end
    end

endmodule

//--- logic/ethBusTop.sv
/*
 * Top level of the Ethernet chip bus controller
 * AXI register slave, reset sequencer and bus cycle engine
 */

`timescale 1ns/1ps

module ethBusTop #(
    parameter int ResetAssertCycles = 491520,
    parameter int ResetWaitCycles   = 2457600
) (
    input  logic                sysclk,
    input  logic                reset,
    // AXI4-Lite slave
    input  ethBusPkg::axiAddr_t awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  ethBusPkg::axiData_t wdata,
    input  logic                wvalid,
    output logic                wready,
    output logic                bvalid,
    input  logic                bready,
    output logic [1:0]          bresp,
    input  ethBusPkg::axiAddr_t araddr,
    input  logic                arvalid,
    output logic                arready,
    output logic                rvalid,
    input  logic                rready,
    output ethBusPkg::axiData_t rdata,
    output logic [1:0]          rresp,
    // Chip pins
    output logic                chipRstN,
    output logic                chipCmd,
    output logic                chipRdN,
    output logic                chipWrN,
    inout  wire  [15:0]         chipData
);

    logic                  cmdStart, cmdDma, cmdWrite, cmdWord;
    ethBusPkg::regOffset_t cmdOffset;
    ethBusPkg::busWord_t   cmdData, lastData;
    logic                  busIdle, softReset, initClear, initReq, chipReady;

    ethAxiRegs ethAxiRegs_inst (
        .sysclk, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bvalid, .bready, .bresp,
        .araddr, .arvalid, .arready, .rvalid, .rready, .rdata, .rresp,
        .busIdle, .lastData,
        .cmdStart, .cmdDma, .cmdWrite, .cmdWord, .cmdOffset, .cmdData,
        .initReq, .chipReady, .softReset, .initClear
    );

    ethChipReset #(
        .ResetAssertCycles (ResetAssertCycles),
        .ResetWaitCycles   (ResetWaitCycles)
    ) ethChipReset_inst (
        .sysclk, .reset, .softReset, .initClear,
        .chipRstN, .initReq, .chipReady
    );

    ethBusCycle ethBusCycle_inst (
        .sysclk, .reset,
        .cmdStart, .cmdDma, .cmdWrite, .cmdWord, .cmdOffset, .cmdData,
        .busIdle, .lastData,
        .chipCmd, .chipRdN, .chipWrN, .chipData
    );

endmodule

//--- tb/ethChipModel.sv
/*
 * Behavioral model of the Ethernet chip host bus
 * Address word latch, 256-byte register array, 16-entry DMA loopback FIFO
 */

`timescale 1ns/1ps

module ethChipModel (
    input logic       chipRstN,
    input logic       chipCmd,
    input logic       chipRdN,
    input logic       chipWrN,
    inout wire [15:0] chipData
);

    logic [7:0]  regMem [256];
    logic [15:0] dmaMem [16];      // Loopback FIFO storage
    logic [3:0]  wrPtr;
    logic [3:0]  rdPtr;
    logic [15:0] lastAddrWord;     // Read by the testbench
    logic        addrValid;        // Address phase seen, data phase pending
    logic        prevWrN;
    logic        prevRdN;
    logic [15:0] rdWord;
    logic [7:0]  base;

    assign base = {lastAddrWord[7:2], 2'b00};   // Start of the 32-bit chunk

    // Read data, enabled bytes only
    always_comb begin
        rdWord = '0;
        if (!addrValid) begin
            rdWord = dmaMem[rdPtr];
        end else begin
            if (lastAddrWord[12]) rdWord[7:0]  = regMem[base];
            if (lastAddrWord[13]) rdWord[15:8] = regMem[base + 8'd1];
            if (lastAddrWord[14]) rdWord[7:0]  = regMem[base + 8'd2];
            if (lastAddrWord[15]) rdWord[15:8] = regMem[base + 8'd3];
        end
    end

    assign chipData = !chipRdN ? rdWord : 16'hzzzz;

    initial begin
        for (int i = 0; i < 256; i++)
            regMem[i] = 8'h00;
        for (int i = 0; i < 16; i++)
            dmaMem[i] = 16'h0000;
        wrPtr        = '0;
        rdPtr        = '0;
        lastAddrWord = '0;
        addrValid    = 1'b0;
        prevWrN      = 1'b1;
        prevRdN      = 1'b1;
    end

    // --------------------
    // Strobe edges
    // --------------------
    always @(chipWrN or chipRdN) begin
        if (chipRstN === 1'b1 && chipWrN === 1'b1 && prevWrN === 1'b0) begin
            if (chipCmd) begin
                lastAddrWord = chipData;   // Address phase
                addrValid    = 1'b1;
            end else if (addrValid) begin
                if (lastAddrWord[12]) regMem[base]         = chipData[7:0];
                if (lastAddrWord[13]) regMem[base + 8'd1]  = chipData[15:8];
                if (lastAddrWord[14]) regMem[base + 8'd2]  = chipData[7:0];
                if (lastAddrWord[15]) regMem[base + 8'd3]  = chipData[15:8];
                addrValid = 1'b0;
            end else begin
                dmaMem[wrPtr] = chipData;  // DMA push
                wrPtr         = wrPtr + 4'd1;
            end
        end
        if (chipRstN === 1'b1 && chipRdN === 1'b1 && prevRdN === 1'b0) begin
            if (!addrValid)
                rdPtr = rdPtr + 4'd1;      // DMA pop after the strobe
            addrValid = 1'b0;
        end
        prevWrN = chipWrN;
        prevRdN = chipRdN;
    end

endmodule

//--- tb/ethBusTb.sv
/*
 * Testbench for the Ethernet chip bus controller
 * Clock, reset, LFSR data, AXI tasks, reference model, checks, watchdog
 */

`timescale 1ns/1ps

module ethBusTb;

    localparam int     AssertCycles = 20;
    localparam int     WaitCycles   = 40;
    localparam int     NumCommands  = 200;
    localparam longint WatchdogNs   = (16 + AssertCycles + WaitCycles + NumCommands * 40) * 100;

    logic                sysclk;
    logic                reset;
    ethBusPkg::axiAddr_t awaddr, araddr;
    ethBusPkg::axiData_t wdata, rdata;
    logic                awvalid, wvalid, bready, arvalid, rready;
    logic                awready, wready, bvalid, arready, rvalid;
    logic [1:0]          bresp, rresp;
    logic                chipRstN, chipCmd, chipRdN, chipWrN;
    wire  [15:0]         chipData;

    logic [7:0]          shadow [256];   // Expected chip register contents
    logic [15:0]         dmaShadow [$];
    logic [15:0]         lfsrState;

    ethBusTop #(
        .ResetAssertCycles (AssertCycles),
        .ResetWaitCycles   (WaitCycles)
    ) ethBusTop_inst (
        .sysclk, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bvalid, .bready, .bresp,
        .araddr, .arvalid, .arready, .rvalid, .rready, .rdata, .rresp,
        .chipRstN, .chipCmd, .chipRdN, .chipWrN, .chipData
    );

    ethChipModel ethChipModel_inst (
        .chipRstN, .chipCmd, .chipRdN, .chipWrN, .chipData
    );

    initial sysclk = 1'b0;
    always #50 sysclk = ~sysclk;

    // Watchdog sized from reset sequence and command budget
    initial begin
        #(WatchdogNs * 1ns);
        $display("Timeout: the test did not finish in the expected time");
        $display("sim failed");
        $fatal(1);
    end

    // --------------------
    // Reference model
    // --------------------
    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] randBits(input int n);
        logic [15:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb        = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], fb};
            v         = {v[14:0], fb};
        end
        return v;
    endfunction

    // Byte enables by access size and position in the 32-bit chunk
    function automatic logic [15:0] refAddrWord(input logic [7:0] off, input logic word);
        logic [3:0] be;
        case ({word, off[1:0]})
            3'b000:  be = 4'b0001;
            3'b001:  be = 4'b0010;
            3'b010:  be = 4'b0100;
            3'b011:  be = 4'b1000;
            3'b100:  be = 4'b0011;   // 16-bit low half
            3'b110:  be = 4'b1100;   // 16-bit high half
            default: be = 4'b0000;   // Odd 16-bit offsets not supported
        endcase
        return {be, 4'h0, off};
    endfunction

    // Even bytes on the low lane, odd bytes on the high lane
    function automatic logic [15:0] refReadWord(input logic [7:0] off, input logic word);
        logic [15:0] a;
        logic [15:0] d;
        logic [7:0]  b;
        a = refAddrWord(off, word);
        b = {off[7:2], 2'b00};
        d = '0;
        if (a[12]) d[7:0]  = shadow[b];
        if (a[13]) d[15:8] = shadow[b + 8'd1];
        if (a[14]) d[7:0]  = shadow[b + 8'd2];
        if (a[15]) d[15:8] = shadow[b + 8'd3];
        return d;
    endfunction

    task automatic refWrite(input logic [7:0] off, input logic word, input logic [15:0] d);
        logic [15:0] a;
        logic [7:0]  b;
        a = refAddrWord(off, word);
        b = {off[7:2], 2'b00};
        if (a[12]) shadow[b]         = d[7:0];
        if (a[13]) shadow[b + 8'd1]  = d[15:8];
        if (a[14]) shadow[b + 8'd2]  = d[7:0];
        if (a[15]) shadow[b + 8'd3]  = d[15:8];
    endtask

    function automatic logic [31:0] makeCmd(input logic dma, input logic rst, input logic wr,
                                            input logic word, input logic [7:0] off,
                                            input logic [15:0] d);
        logic [31:0] c;
        c = '0;
        c[ethBusPkg::CmdDmaBit]   = dma;
        c[ethBusPkg::CmdResetBit] = rst;
        c[ethBusPkg::CmdWriteBit] = wr;
        c[ethBusPkg::CmdWordBit]  = word;
        c[23:16] = off;
        c[15:0]  = d;
        return c;
    endfunction

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // --------------------
    // AXI master tasks
    // --------------------
    task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data, input int holdB);
        @(posedge sysclk);
        #5;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        forever begin
            @(posedge sysclk);
            #1;
            if (awready) break;
        end
        checkEq("wready", wready, 1'b1);
        @(posedge sysclk);   // Handshake edge
        #4;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        checkEq("bvalid", bvalid, 1'b1);
        for (int i = 0; i < holdB; i++) begin
            @(posedge sysclk);
            #5;
            checkEq("bvalid held", bvalid, 1'b1);
            checkEq("bresp", bresp, 2'b00);
        end
        bready = 1'b1;
        @(posedge sysclk);
        #5;
        bready = 1'b0;
        checkEq("bvalid cleared", bvalid, 1'b0);
    endtask

    task automatic axiRead(input logic [3:0] addr, output logic [31:0] data, input int holdR);
        logic [31:0] first;
        @(posedge sysclk);
        #5;
        araddr  = addr;
        arvalid = 1'b1;
        forever begin
            @(posedge sysclk);
            #1;
            if (arready) break;
        end
        @(posedge sysclk);
        #4;
        arvalid = 1'b0;
        checkEq("rvalid", rvalid, 1'b1);
        checkEq("rresp", rresp, 2'b00);
        first = rdata;
        for (int i = 0; i < holdR; i++) begin
            @(posedge sysclk);
            #5;
            checkEq("rvalid held", rvalid, 1'b1);
            checkEq("rdata held", rdata, first);
        end
        data   = rdata;
        rready = 1'b1;
        @(posedge sysclk);
        #5;
        rready = 1'b0;
        checkEq("rvalid cleared", rvalid, 1'b0);
    endtask

    task automatic waitIdle(output logic [31:0] st);
        for (int i = 0; i < 50; i++) begin
            axiRead(ethBusPkg::RegStatus, st, 0);
            if (st[ethBusPkg::StatIdleBit]) return;
        end
        $display("Bus engine never returned to idle");
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic waitInitReq(output logic [31:0] st);
        for (int i = 0; i < 40; i++) begin
            axiRead(ethBusPkg::RegStatus, st, 0);
            if (st[ethBusPkg::StatInitReqBit]) return;
        end
        $display("Init request did not return after the reset sequence");
        $display("sim failed");
        $fatal(1);
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        logic [31:0] st;
        logic [7:0]  off;
        logic        word;
        logic [15:0] d;
        logic [15:0] addrBefore;
        int          n;

        reset   = 1'b0;
        awaddr  = '0;
        araddr  = '0;
        wdata   = '0;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        arvalid = 1'b0;
        rready  = 1'b0;
        lfsrState = 16'd41;
        for (int i = 0; i < 256; i++)
            shadow[i] = 8'h00;

        repeat (16) @(posedge sysclk);
        #5;
        checkEq("chipRstN in reset", chipRstN, 1'b0);
        checkEq("chipWrN in reset", chipWrN, 1'b1);
        checkEq("chipRdN in reset", chipRdN, 1'b1);
        checkEq("chipCmd in reset", chipCmd, 1'b1);
        checkEq("bvalid in reset", bvalid, 1'b0);
        checkEq("rvalid in reset", rvalid, 1'b0);
        reset = 1'b1;

        // Reset pin low time, then settling time before init request
        n = 0;
        while (!chipRstN && n < 1000) begin
            @(posedge sysclk);
            n++;
            #1;
        end
        checkEq("reset low cycles", n, AssertCycles);
        n = 0;
        while (!ethBusTop_inst.ethChipReset_inst.initReq && n < 1000) begin
            @(posedge sysclk);
            n++;
            #1;
        end
        checkEq("settle cycles", n, WaitCycles);
        axiRead(ethBusPkg::RegStatus, st, 0);
        checkEq("present", st[ethBusPkg::StatPresentBit], 1'b1);
        checkEq("initReq set", st[ethBusPkg::StatInitReqBit], 1'b1);
        axiWrite(ethBusPkg::RegControl, 32'h1, 0);
        axiRead(ethBusPkg::RegStatus, st, 0);
        checkEq("initReq cleared", st[ethBusPkg::StatInitReqBit], 1'b0);

        // Random register writes and read-backs
        for (int i = 0; i < 40; i++) begin
            word = 1'(randBits(1));
            off  = 8'(randBits(8));
            if (word) off[0] = 1'b0;
            d = randBits(16);
            axiWrite(ethBusPkg::RegCommand, makeCmd(0, 0, 1, word, off, d), 0);
            waitIdle(st);
            refWrite(off, word, d);
            checkEq("write lastData", st[15:0], d);
            checkEq("write addr word", ethChipModel_inst.lastAddrWord, refAddrWord(off, word));
            axiWrite(ethBusPkg::RegCommand, makeCmd(0, 0, 0, word, off, 16'h0), 0);
            waitIdle(st);
            checkEq("read lastData", st[15:0], refReadWord(off, word));
            checkEq("read addr word", ethChipModel_inst.lastAddrWord, refAddrWord(off, word));
        end

        // DMA loopback, data only
        addrBefore = ethChipModel_inst.lastAddrWord;
        for (int i = 0; i < 8; i++) begin
            d = randBits(16);
            dmaShadow.push_back(d);
            axiWrite(ethBusPkg::RegCommand, makeCmd(1, 0, 1, 1, 8'h00, d), 0);
            waitIdle(st);
        end
        for (int i = 0; i < 8; i++) begin
            axiWrite(ethBusPkg::RegCommand, makeCmd(1, 0, 0, 1, 8'h00, 16'h0), 0);
            waitIdle(st);
            checkEq("dma read", st[15:0], dmaShadow.pop_front());
        end
        checkEq("dma addr word", ethChipModel_inst.lastAddrWord, addrBefore);

        // Command while busy is dropped
        off = {7'(randBits(7)), 1'b0};
        d   = randBits(16);
        axiWrite(ethBusPkg::RegCommand, makeCmd(0, 0, 1, 1, off, d), 0);
        axiWrite(ethBusPkg::RegCommand, makeCmd(0, 0, 1, 1, off, ~d), 0);
        refWrite(off, 1'b1, d);
        waitIdle(st);
        checkEq("busy error", st[ethBusPkg::StatErrorBit], 1'b1);
        axiWrite(ethBusPkg::RegCommand, makeCmd(0, 0, 0, 1, off, 16'h0), 0);
        waitIdle(st);
        checkEq("busy error cleared", st[ethBusPkg::StatErrorBit], 1'b0);
        checkEq("dropped write", st[15:0], refReadWord(off, 1'b1));

        // Back-pressure on both channels
        d = randBits(16);
        axiWrite(ethBusPkg::RegCommand, makeCmd(0, 0, 1, 1, 8'h10, d), 3);
        refWrite(8'h10, 1'b1, d);
        waitIdle(st);
        axiRead(ethBusPkg::RegStatus, st, 3);
        checkEq("stalled status", st[15:0], d);

        // Software reset, a command before ready must leave lastData alone
        axiWrite(ethBusPkg::RegCommand, makeCmd(0, 1, 0, 0, 8'h00, 16'h0), 0);
        checkEq("soft reset pin", chipRstN, 1'b0);
        axiWrite(ethBusPkg::RegCommand, makeCmd(0, 0, 1, 1, 8'h20, 16'h1234), 0);
        axiRead(ethBusPkg::RegStatus, st, 0);
        checkEq("not ready error", st[ethBusPkg::StatErrorBit], 1'b1);
        checkEq("not ready write dropped", st[15:0], d);
        waitInitReq(st);

        // Second reset with the init request still pending
        axiWrite(ethBusPkg::RegCommand, makeCmd(0, 1, 0, 0, 8'h00, 16'h0), 0);
        axiRead(ethBusPkg::RegStatus, st, 0);
        checkEq("soft reset initReq", st[ethBusPkg::StatInitReqBit], 1'b0);
        waitInitReq(st);
        axiWrite(ethBusPkg::RegControl, 32'h1, 0);
        axiWrite(ethBusPkg::RegCommand, makeCmd(0, 0, 0, 1, 8'h20, 16'h0), 0);
        waitIdle(st);
        checkEq("ready error cleared", st[ethBusPkg::StatErrorBit], 1'b0);
        checkEq("read after soft reset", st[15:0], refReadWord(8'h20, 1'b1));
        checkEq("initReq after clear", st[ethBusPkg::StatInitReqBit], 1'b0);

        $display("sim passed");
        $finish;
    end

endmodule

//--- list.f
logic/ethBusPkg.sv
logic/ethAxiRegs.sv
logic/ethChipReset.sv
logic/ethBusCycle.sv
logic/ethBusTop.sv
tb/ethChipModel.sv
tb/ethBusTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the bus controller testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
    --top-module ethBusTb \
    -f list.f \
    -o simv

./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log; then
    exit 1
fi
exit 0
